// ==== build.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/mem_read_if.sv
logic/fetch_unit.sv
logic/mem_read_bridge.sv
logic/core_fetch_wrapper.sv
test/fetch_mem_model.sv
test/tb_core_fetch_wrapper.sv

// ==== logic/core_fetch_wrapper.sv ====
module core_fetch_wrapper import fetch_pkg::*; (
    // Clock and reset
    input  logic         clk_i,
    input  logic         reset_i,

    // Level-sensitive interrupt
    input  logic         irq_i,

    // Memory port
    output logic         mem_req_o,
    output logic [63:0]  mem_addr_o,
    input  logic [63:0]  mem_rdata_i,

    // Instruction pair with the address of slot 0
    output instr_t [1:0] instr_o,
    output logic [63:0]  addr_o,
    output logic         instruction_valid_o
);

    localparam int unsigned ADDR_W = $bits(fetch_addr_t);

    fetch_addr_t bridge_addr;
    fetch_addr_t fetch_addr;

    mem_read_if bus_if (
        .clk_i (clk_i)
    );

    // ------------------------------
    // Fetch side
    // ------------------------------

    fetch_unit u_fetch (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .irq_i               (irq_i),
        .bus                 (bus_if.fetch),
        .instr_o             (instr_o),
        .addr_o              (fetch_addr),
        .instruction_valid_o (instruction_valid_o)
    );

    // ------------------------------
    // Memory side
    // ------------------------------

    mem_read_bridge u_bridge (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .bus         (bus_if.bridge),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (bridge_addr),
        .mem_rdata_i (mem_rdata_i)
    );

    // Top byte repeats bit 55
    assign mem_addr_o = {{(64 - ADDR_W){bridge_addr[ADDR_W-1]}}, bridge_addr};
    assign addr_o     = {{(64 - ADDR_W){fetch_addr[ADDR_W-1]}}, fetch_addr};

endmodule

// ==== logic/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ------------------------------
// Fetch configuration
// ------------------------------

// First line fetched after reset
`define FETCH_BOOT_ADDR 56'h0000_8000_0000

// Interrupt redirect target, line aligned
`define FETCH_TRAP_VEC 56'h0000_8000_0400

// Beats per line burst
`define FETCH_LINE_BEATS 4

// Burst length field, holds beats minus one
`define FETCH_LEN_W 2

`endif

// ==== logic/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

    // ------------------------------
    // Bus payloads
    // ------------------------------

    // Byte address inside the design, sign-extended at the top level
    typedef logic [55:0] fetch_addr_t;

    // One memory word, two instructions
    typedef logic [63:0] beat_t;

    typedef logic [31:0] instr_t;

    // Beats minus one on the request channel
    typedef logic [`FETCH_LEN_W-1:0] burst_len_t;

    // ------------------------------
    // Request sequencer
    // ------------------------------

    typedef enum logic {
        FETCH_IDLE,
        FETCH_REQ
    } fetch_state_e;

endpackage

// ==== logic/fetch_unit.sv ====
`include "fetch_cfg.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         irq_i,

    mem_read_if.fetch    bus,

    output instr_t [1:0] instr_o,
    output fetch_addr_t  addr_o,
    output logic         instruction_valid_o
);

    // Address steps for one beat and one whole line
    localparam fetch_addr_t BEAT_STEP = fetch_addr_t'($bits(beat_t) / 8);
    localparam fetch_addr_t LINE_STEP = fetch_addr_t'(`FETCH_LINE_BEATS * ($bits(beat_t) / 8));

    fetch_state_e state_q;
    fetch_addr_t  req_addr_q;
    logic         req_fire;

    logic         irq_q;
    logic         irq_rise;
    logic         irq_pending_q;

    // Issued line addresses, one per burst in flight
    fetch_addr_t  line_rec_q [2];
    logic         rec_wr_q;
    logic         rec_rd_q;

    logic         line_start_q;
    fetch_addr_t  beat_addr_q;
    fetch_addr_t  cur_addr;

    // ------------------------------
    // Request sequencer
    // ------------------------------

    assign bus.req_valid = (state_q == FETCH_REQ);
    assign bus.req_addr  = req_addr_q;
    assign bus.req_len   = burst_len_t'(`FETCH_LINE_BEATS - 1);

    assign req_fire = bus.req_valid && bus.req_ready;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= FETCH_IDLE;
            req_addr_q <= `FETCH_BOOT_ADDR;
        end else begin
            case (state_q)
                // One quiet cycle out of reset, then keep the channel busy
                FETCH_IDLE: begin
                    state_q <= FETCH_REQ;
                end
                FETCH_REQ: begin
                    // Address only moves once the current line is taken
                    if (req_fire) begin
                        if (irq_pending_q) begin
                            req_addr_q <= `FETCH_TRAP_VEC;
                        end else begin
                            req_addr_q <= req_addr_q + LINE_STEP;
                        end
                    end
                end
                default: begin
                    state_q <= FETCH_IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // Interrupt redirect
    // ------------------------------

    // Level input, only a low to high change counts
    assign irq_rise = irq_i && !irq_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_q         <= 1'b0;
            irq_pending_q <= 1'b0;
        end else begin
            irq_q <= irq_i;
            // A fresh edge wins over the one being consumed
            if (irq_rise) begin
                irq_pending_q <= 1'b1;
            end else if (req_fire) begin
                irq_pending_q <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Return address tracking
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            line_rec_q[rec_wr_q] <= bus.req_addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rec_wr_q     <= 1'b0;
            rec_rd_q     <= 1'b0;
            line_start_q <= 1'b1;
        end else begin
            if (req_fire) begin
                rec_wr_q <= !rec_wr_q;
            end
            if (bus.beat_valid) begin
                line_start_q <= bus.beat_last;
                if (bus.beat_last) begin
                    rec_rd_q <= !rec_rd_q;
                end
            end
        end
    end

    // First beat of a line takes its address from the record
    assign cur_addr = line_start_q ? line_rec_q[rec_rd_q] : beat_addr_q;

    always_ff @(posedge clk_i) begin
        if (bus.beat_valid) begin
            beat_addr_q <= cur_addr + BEAT_STEP;
        end
    end

    // ------------------------------
    // Instruction output register
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instruction_valid_o <= 1'b0;
        end else begin
            instruction_valid_o <= bus.beat_valid;
        end
    end

    // Lower half is the lower address
    always_ff @(posedge clk_i) begin
        if (bus.beat_valid) begin
            instr_o[0] <= bus.beat_data[31:0];
            instr_o[1] <= bus.beat_data[63:32];
            addr_o     <= cur_addr;
        end
    end

endmodule

// ==== logic/mem_read_bridge.sv ====
`include "fetch_cfg.svh"

module mem_read_bridge import fetch_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    mem_read_if.bridge  bus,

    // Synchronous memory, data returns one cycle after the strobe
    output logic        mem_req_o,
    output fetch_addr_t mem_addr_o,
    input  beat_t       mem_rdata_i
);

    localparam fetch_addr_t BEAT_STEP = fetch_addr_t'($bits(beat_t) / 8);

    logic                    busy_q;
    logic [`FETCH_LEN_W-1:0] beat_cnt_q;
    fetch_addr_t             strobe_addr_q;
    logic                    last_strobe;
    logic                    req_fire;

    logic                    beat_valid_q;
    logic                    beat_last_q;

    // ------------------------------
    // Request acceptance
    // ------------------------------

    assign last_strobe = busy_q && (beat_cnt_q == '0);

    // Also ready on the final strobe so bursts run back to back
    assign bus.req_ready = !busy_q || last_strobe;

    assign req_fire = bus.req_valid && bus.req_ready;

    // ------------------------------
    // Strobe sequencing
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q     <= 1'b0;
            beat_cnt_q <= '0;
        end else begin
            if (req_fire) begin
                busy_q     <= 1'b1;
                beat_cnt_q <= bus.req_len;
            end else if (last_strobe) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                beat_cnt_q <= beat_cnt_q - 1'b1;
            end
        end
    end

    // Start of burst comes from the request, then one word per cycle
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            strobe_addr_q <= bus.req_addr;
        end else if (busy_q) begin
            strobe_addr_q <= strobe_addr_q + BEAT_STEP;
        end
    end

    assign mem_req_o  = busy_q;
    assign mem_addr_o = strobe_addr_q;

    // ------------------------------
    // Beat return
    // ------------------------------

    // Strobe and last flag delayed to line up with the read data
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            beat_valid_q <= 1'b0;
            beat_last_q  <= 1'b0;
        end else begin
            beat_valid_q <= busy_q;
            beat_last_q  <= last_strobe;
        end
    end

    assign bus.beat_valid = beat_valid_q;
    assign bus.beat_last  = beat_last_q;
    assign bus.beat_data  = mem_rdata_i;

endmodule

// ==== logic/mem_read_if.sv ====
interface mem_read_if import fetch_pkg::*; (
    input logic clk_i
);

    // Request channel, transfers when valid and ready are both high
    logic        req_valid;
    logic        req_ready;
    fetch_addr_t req_addr;
    burst_len_t  req_len;

    // Beat channel, always accepted by the fetch side
    logic        beat_valid;
    beat_t       beat_data;
    logic        beat_last;

    modport fetch (
        input  clk_i,
        output req_valid,
        output req_addr,
        output req_len,
        input  req_ready,
        input  beat_valid,
        input  beat_data,
        input  beat_last
    );

    modport bridge (
        input  clk_i,
        input  req_valid,
        input  req_addr,
        input  req_len,
        output req_ready,
        output beat_valid,
        output beat_data,
        output beat_last
    );

endinterface

// ==== test/fetch_mem_model.sv ====
module fetch_mem_model (
    input  logic        clk_i,
    input  logic        mem_req_i,
    input  logic [63:0] mem_addr_i,
    output logic [63:0] mem_rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------
    // Memory contents
    // ------------------------------

    // Every 32-bit word is a mix of all bits of its own byte address
    function automatic logic [31:0] word_at(input logic [63:0] byte_addr);
        logic [31:0] mixed;
        mixed = {byte_addr[15:0] ^ byte_addr[47:32], byte_addr[31:16] ^ byte_addr[63:48]};
        return mixed ^ 32'h5A3C_96E1;
    endfunction

    initial begin
        mem_rdata_o = '0;
    end

    // Synchronous read, data follows the strobe by one cycle
    always @(posedge clk_i) begin
        if (mem_req_i) begin
            mem_rdata_o <= {word_at(mem_addr_i + 64'd4), word_at(mem_addr_i)};
        end
    end

endmodule

// ==== test/tb_core_fetch_wrapper.sv ====
`include "fetch_cfg.svh"

module tb_core_fetch_wrapper;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT    = 4000;
    localparam int LINE_BEATS     = `FETCH_LINE_BEATS;
    localparam int SEQ_LINES      = 100;
    localparam int REDIRECT_LIMIT = 3 * LINE_BEATS;

    logic              clk_i;
    logic              reset_i;
    logic              irq_i;
    logic              mem_req;
    logic [63:0]       mem_addr;
    logic [63:0]       mem_rdata;
    logic [1:0][31:0]  instr;
    logic [63:0]       addr;
    logic              instr_valid;

    // State shared by stimulus and compare process
    string             test_name = "reset";
    int                cycle_count = 0;
    int                error_count = 0;
    int                valid_count = 0;
    int                jump_count = 0;
    int                beats_since_irq = 0;
    int                first_req_cycle = -1;
    logic              redirect_expected = 1'b0;
    logic              have_prev = 1'b0;
    logic              reset_prev = 1'b0;
    logic [63:0]       prev_addr = '0;

    core_fetch_wrapper core_fetch_wrapper_i (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .irq_i               (irq_i),
        .mem_req_o           (mem_req),
        .mem_addr_o          (mem_addr),
        .mem_rdata_i         (mem_rdata),
        .instr_o             (instr),
        .addr_o              (addr),
        .instruction_valid_o (instr_valid)
    );

    fetch_mem_model mem_model_i (
        .clk_i       (clk_i),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_rdata_o (mem_rdata)
    );

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [31:0] expected_word(input logic [63:0] byte_addr);
        logic [31:0] mixed;
        mixed = {byte_addr[15:0] ^ byte_addr[47:32], byte_addr[31:16] ^ byte_addr[63:48]};
        return mixed ^ 32'h5A3C_96E1;
    endfunction

    function automatic logic [63:0] extend_addr(input logic [55:0] short_addr);
        return {{8{short_addr[55]}}, short_addr};
    endfunction

    localparam logic [63:0] BOOT_ADDR = extend_addr(`FETCH_BOOT_ADDR);
    localparam logic [63:0] TRAP_ADDR = extend_addr(`FETCH_TRAP_VEC);

    // ------------------------------
    // Failure reporting
    // ------------------------------

    task automatic report_failure();
        error_count++;
        $display("sim failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic value_mismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
        $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
        report_failure();
    endtask

    task automatic event_failure(input string message);
        $display("Error in test %s: %s", test_name, message);
        report_failure();
    endtask

    // ------------------------------
    // Clock and timeout
    // ------------------------------

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            report_failure();
        end
    end

    // ------------------------------
    // Compare process
    // ------------------------------

    task automatic check_output();
        logic [63:0] step_addr;
        step_addr = prev_addr + 64'd8;
        assert (instr[0] == expected_word(addr))
            else value_mismatch("slot 0", expected_word(addr), instr[0]);
        assert (instr[1] == expected_word(addr + 64'd4))
            else value_mismatch("slot 1", expected_word(addr + 64'd4), instr[1]);
        if (!have_prev) begin
            assert (addr == BOOT_ADDR)
                else value_mismatch("first address after reset", BOOT_ADDR, addr);
            assert (first_req_cycle >= 0)
                else event_failure("an instruction came out before any memory request");
            assert (cycle_count - first_req_cycle == 2)
                else value_mismatch("cycles from mem_req_o to output", 64'd2,
                                    64'(cycle_count - first_req_cycle));
        end else if (addr != step_addr) begin
            assert (redirect_expected)
                else event_failure("the address stream jumped with no interrupt edge");
            assert (addr == TRAP_ADDR)
                else value_mismatch("redirect target", TRAP_ADDR, addr);
            redirect_expected = 1'b0;
            jump_count++;
        end
        // Still waiting for the jump
        if (redirect_expected) begin
            beats_since_irq++;
            assert (beats_since_irq <= REDIRECT_LIMIT)
                else event_failure("no redirect within three lines of the interrupt edge");
        end
        have_prev   = 1'b1;
        prev_addr   = addr;
        valid_count++;
    endtask

    // Sampled mid-cycle once all DUT outputs have settled
    always @(negedge clk_i) begin
        if (reset_i) begin
            // Reset has seen at least one clock edge
            if (reset_prev) begin
                assert (!instr_valid) else event_failure("instruction_valid_o high in reset");
                assert (!mem_req) else event_failure("mem_req_o high in reset");
            end
            have_prev       = 1'b0;
            valid_count     = 0;
            first_req_cycle = -1;
        end else begin
            if (mem_req) begin
                assert (mem_addr[63:56] == {8{mem_addr[55]}})
                    else value_mismatch("mem_addr_o top byte", {56'b0, {8{mem_addr[55]}}},
                                        {56'b0, mem_addr[63:56]});
                if (first_req_cycle < 0) begin
                    first_req_cycle = cycle_count;
                end
            end
            if (instr_valid) begin
                check_output();
            end
        end
        reset_prev = reset_i;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) next_cycle();
    endtask

    task automatic raise_irq_and_wait_jump();
        int target;
        target          = jump_count + 1;
        irq_i           = 1'b1;
        beats_since_irq = 0;
        redirect_expected = 1'b1;
        while (jump_count < target) begin
            next_cycle();
        end
    endtask

    initial begin
        int delay;
        void'($urandom(40));
        reset_i = 1'b1;
        irq_i   = 1'b0;
        wait_cycles(10);
        reset_i = 1'b0;

        // Boot address and memory-to-output latency
        while (valid_count < 1) begin
            next_cycle();
        end

        test_name = "sequence";
        while (valid_count < SEQ_LINES * LINE_BEATS) begin
            next_cycle();
        end

        test_name = "redirect";
        delay = 5 + int'($urandom % 40);
        wait_cycles(delay);
        raise_irq_and_wait_jump();
        wait_cycles(3 * LINE_BEATS);

        // Level held high gives no second jump
        test_name = "level";
        wait_cycles(80);
        irq_i = 1'b0;
        wait_cycles(2 + int'($urandom % 8));
        raise_irq_and_wait_jump();
        irq_i = 1'b0;
        wait_cycles(3 * LINE_BEATS);

        test_name = "second reset";
        wait_cycles(3 + int'($urandom % 7));
        reset_i = 1'b1;
        wait_cycles(10);
        reset_i = 1'b0;
        while (valid_count < 2 * LINE_BEATS) begin
            next_cycle();
        end

        if (error_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule
